/* verilog/mduPkg.sv */
package mduPkg;

	//////////////////////////////////////////////////////////////////////
	// Command codes
	//////////////////////////////////////////////////////////////////////

	// Multiply and divide go to the shared engine,
	// moves are retired inside the issue port
	typedef enum logic [2:0]
	{
		opMult  = 3'd0,
		opMultu = 3'd1,
		opDiv   = 3'd2,
		opDivu  = 3'd3,
		opMthi  = 3'd4,
		opMtlo  = 3'd5
	} mduOp;

	//////////////////////////////////////////////////////////////////////
	// Widths and latencies
	//////////////////////////////////////////////////////////////////////

	// Operand and HI/LO width
	localparam int DataWidth = 32;

	// Cycles from the start edge to resultValid
	localparam int MultLatency = 5;
	localparam int DivLatency = 10;

	// True for commands that need the engine
	function automatic logic isEngineOp(input mduOp op);
		return (op == opMult) || (op == opMultu) || (op == opDiv) || (op == opDivu);
	endfunction

	// True for either divide
	function automatic logic isDivOp(input mduOp op);
		return (op == opDiv) || (op == opDivu);
	endfunction

endpackage

/* verilog/mduIssuePort.sv */
`timescale 1ns/1ps

module mduIssuePort #(
	parameter int CmdDepth = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic cmdValid,
	input  mduPkg::mduOp cmdOp,
	input  logic [mduPkg::DataWidth-1:0] cmdSrcA,
	input  logic [mduPkg::DataWidth-1:0] cmdSrcB,
	input  logic grant,
	input  logic respValid,
	input  logic [mduPkg::DataWidth-1:0] respHi,
	input  logic [mduPkg::DataWidth-1:0] respLo,
	output logic cmdCredit,
	output logic reqValid,
	output mduPkg::mduOp reqOp,
	output logic [mduPkg::DataWidth-1:0] reqSrcA,
	output logic [mduPkg::DataWidth-1:0] reqSrcB,
	output logic [mduPkg::DataWidth-1:0] hi,
	output logic [mduPkg::DataWidth-1:0] lo,
	output logic done
);
	import mduPkg::*;

	localparam int PtrWidth = (CmdDepth > 1) ? $clog2(CmdDepth) : 1;
	localparam int CountWidth = $clog2(CmdDepth + 1);

	// Command storage
	mduOp opMem [CmdDepth];
	logic [DataWidth-1:0] srcAMem [CmdDepth];
	logic [DataWidth-1:0] srcBMem [CmdDepth];

	logic [PtrWidth-1:0] writePtr;
	logic [PtrWidth-1:0] readPtr;
	logic [CountWidth-1:0] count;

	logic headValid;
	mduOp headOp;
	logic waiting;
	logic movePop;
	logic pop;

	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		if (ptr == PtrWidth'(CmdDepth - 1))
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Head of queue and retire decision
	//////////////////////////////////////////////////////////////////////

	assign headValid = (count != '0);
	assign headOp = opMem[readPtr];

	// Nothing leaves the head while an engine result is pending
	assign reqValid = headValid && !waiting && isEngineOp(headOp);
	assign reqOp = headOp;
	assign reqSrcA = srcAMem[readPtr];
	assign reqSrcB = srcBMem[readPtr];

	assign movePop = headValid && !waiting && !isEngineOp(headOp);
	assign pop = movePop || grant;

	// Payload write at the tail
	always_ff @(posedge clk)
	begin
		if (cmdValid)
		begin
			opMem[writePtr] <= cmdOp;
			srcAMem[writePtr] <= cmdSrcA;
			srcBMem[writePtr] <= cmdSrcB;
		end
	end

	// Pointers, occupancy and credit return
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			writePtr <= '0;
			readPtr <= '0;
			count <= '0;
			cmdCredit <= 1'b0;
		end
		else
		begin
			if (cmdValid)
				writePtr <= nextPtr(writePtr);
			if (pop)
				readPtr <= nextPtr(readPtr);
			if (cmdValid && !pop)
				count <= count + 1'b1;
			else if (!cmdValid && pop)
				count <= count - 1'b1;
			cmdCredit <= pop;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// HI/LO and completion
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			waiting <= 1'b0;
			hi <= '0;
			lo <= '0;
			done <= 1'b0;
		end
		else
		begin
			// Set on grant and cleared by our own result
			if (grant)
				waiting <= 1'b1;
			else if (respValid)
				waiting <= 1'b0;

			if (respValid)
			begin
				hi <= respHi;
				lo <= respLo;
			end
			else if (movePop)
			begin
				if (headOp == opMthi)
					hi <= srcAMem[readPtr];
				else
					lo <= srcAMem[readPtr];
			end
			done <= respValid || movePop;
		end
	end

	// Sender honours its credits, so the queue never overflows
	assert property (@(posedge clk) disable iff (reset)
		cmdValid |-> (count != CountWidth'(CmdDepth)))
		else $error("mduIssuePort: command written into a full queue");

	// The arbiter routes results only to the port that was granted
	assert property (@(posedge clk) disable iff (reset) respValid |-> waiting)
		else $error("mduIssuePort: result received with no operation outstanding");

endmodule

/* verilog/mduArbiter.sv */
`timescale 1ns/1ps

module mduArbiter #(
	parameter int NumPorts = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic [NumPorts-1:0] reqValid,
	input  mduPkg::mduOp [NumPorts-1:0] reqOp,
	input  logic [NumPorts-1:0][mduPkg::DataWidth-1:0] reqSrcA,
	input  logic [NumPorts-1:0][mduPkg::DataWidth-1:0] reqSrcB,
	input  logic resultValid,
	input  logic [mduPkg::DataWidth-1:0] resultHi,
	input  logic [mduPkg::DataWidth-1:0] resultLo,
	output logic [NumPorts-1:0] grant,
	output logic start,
	output mduPkg::mduOp op,
	output logic [mduPkg::DataWidth-1:0] srcA,
	output logic [mduPkg::DataWidth-1:0] srcB,
	output logic [NumPorts-1:0] respValid,
	output logic [mduPkg::DataWidth-1:0] respHi,
	output logic [mduPkg::DataWidth-1:0] respLo
);
	import mduPkg::*;

	localparam int IdxWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

	logic [IdxWidth-1:0] lastGrant;
	logic [IdxWidth-1:0] owner;
	logic ownerValid;
	logic [IdxWidth-1:0] winner;
	logic anyReq;

	//////////////////////////////////////////////////////////////////////
	// Round-robin search
	//////////////////////////////////////////////////////////////////////

	// Start one past the last winner and take the first requester
	always_comb
	begin : search
		int cand;
		winner = lastGrant;
		anyReq = 1'b0;
		for (int k = 1; k <= NumPorts; k++)
		begin
			cand = (int'(lastGrant) + k) % NumPorts;
			if (!anyReq && reqValid[cand])
			begin
				winner = IdxWidth'(cand);
				anyReq = 1'b1;
			end
		end
	end

	always_comb
	begin
		grant = '0;
		if (anyReq && !ownerValid)
			grant[winner] = 1'b1;
	end

	assign start = |grant;
	assign op = reqOp[winner];
	assign srcA = reqSrcA[winner];
	assign srcB = reqSrcB[winner];

	// Owner of the engine operation in flight
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ownerValid <= 1'b0;
			owner <= '0;
			lastGrant <= IdxWidth'(NumPorts - 1);
		end
		else if (start)
		begin
			ownerValid <= 1'b1;
			owner <= winner;
			lastGrant <= winner;
		end
		else if (resultValid)
			ownerValid <= 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Result return
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		respValid = '0;
		if (resultValid && ownerValid)
			respValid[owner] = 1'b1;
	end

	assign respHi = resultHi;
	assign respLo = resultLo;

	assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
		else $error("mduArbiter: more than one grant");

	// Engine completes only what was started through us
	assert property (@(posedge clk) disable iff (reset) resultValid |-> ownerValid)
		else $error("mduArbiter: engine result with no owner");

endmodule

/* verilog/mduEngine.sv */
`timescale 1ns/1ps

module mduEngine (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  mduPkg::mduOp op,
	input  logic [mduPkg::DataWidth-1:0] srcA,
	input  logic [mduPkg::DataWidth-1:0] srcB,
	output logic resultValid,
	output logic [mduPkg::DataWidth-1:0] resultHi,
	output logic [mduPkg::DataWidth-1:0] resultLo
);
	import mduPkg::*;

	localparam int CountWidth = $clog2(DivLatency + 1);
	localparam logic [DataWidth-1:0] MinValue = {1'b1, {(DataWidth - 1){1'b0}}};

	logic [CountWidth-1:0] count;
	mduOp opReg;
	logic [DataWidth-1:0] aReg;
	logic [DataWidth-1:0] bReg;

	logic signed [2*DataWidth-1:0] prodSigned;
	logic [2*DataWidth-1:0] prodUnsigned;
	logic [DataWidth-1:0] quotient;
	logic [DataWidth-1:0] remainder;

	//////////////////////////////////////////////////////////////////////
	// Arithmetic on the latched operands
	//////////////////////////////////////////////////////////////////////

	// Sign-extend to full width so the product keeps all 64 bits
	assign prodSigned = $signed({{DataWidth{aReg[DataWidth-1]}}, aReg})
		* $signed({{DataWidth{bReg[DataWidth-1]}}, bReg});
	assign prodUnsigned = {{DataWidth{1'b0}}, aReg} * {{DataWidth{1'b0}}, bReg};

	always_comb
	begin
		if (bReg == '0)
		begin
			// Divide by zero gives the same result signed or unsigned
			quotient = '1;
			remainder = aReg;
		end
		else if (opReg == opDiv && aReg == MinValue && bReg == '1)
		begin
			quotient = MinValue;
			remainder = '0;
		end
		else if (opReg == opDiv)
		begin
			// Quotient truncates toward zero and the remainder follows the dividend
			quotient = DataWidth'($signed(aReg) / $signed(bReg));
			remainder = DataWidth'($signed(aReg) % $signed(bReg));
		end
		else
		begin
			quotient = aReg / bReg;
			remainder = aReg % bReg;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Latency counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			if (start)
				count <= isDivOp(op) ? CountWidth'(DivLatency) : CountWidth'(MultLatency);
			else if (count != '0)
				count <= count - 1'b1;
			resultValid <= (count == CountWidth'(1));
		end
	end

	// Operand latch and result capture
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			opReg <= op;
			aReg <= srcA;
			bReg <= srcB;
		end
		if (count == CountWidth'(1))
		begin
			case (opReg)
				opMult:
					{resultHi, resultLo} <= prodSigned;
				opMultu:
					{resultHi, resultLo} <= prodUnsigned;
				default:
				begin
					resultHi <= remainder;
					resultLo <= quotient;
				end
			endcase
		end
	end

	// Arbiter must hold off until the previous result is out
	assert property (@(posedge clk) disable iff (reset) start |-> (count == '0))
		else $error("mduEngine: start while an operation is running");

endmodule

/* verilog/mduCluster.sv */
`timescale 1ns/1ps

module mduCluster #(
	parameter int NumPorts = 2,
	parameter int CmdDepth = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic [NumPorts-1:0] cmdValid,
	input  mduPkg::mduOp [NumPorts-1:0] cmdOp,
	input  logic [NumPorts-1:0][mduPkg::DataWidth-1:0] cmdSrcA,
	input  logic [NumPorts-1:0][mduPkg::DataWidth-1:0] cmdSrcB,
	output logic [NumPorts-1:0] cmdCredit,
	output logic [NumPorts-1:0][mduPkg::DataWidth-1:0] hi,
	output logic [NumPorts-1:0][mduPkg::DataWidth-1:0] lo,
	output logic [NumPorts-1:0] done
);
	import mduPkg::*;

	// Port to arbiter
	logic [NumPorts-1:0] reqValid;
	mduOp [NumPorts-1:0] reqOp;
	logic [NumPorts-1:0][DataWidth-1:0] reqSrcA;
	logic [NumPorts-1:0][DataWidth-1:0] reqSrcB;
	logic [NumPorts-1:0] grant;
	logic [NumPorts-1:0] respValid;
	logic [DataWidth-1:0] respHi;
	logic [DataWidth-1:0] respLo;

	// Arbiter to engine
	logic start;
	mduOp engOp;
	logic [DataWidth-1:0] engSrcA;
	logic [DataWidth-1:0] engSrcB;
	logic resultValid;
	logic [DataWidth-1:0] resultHi;
	logic [DataWidth-1:0] resultLo;

	//////////////////////////////////////////////////////////////////////
	// Issue ports
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NumPorts; i++)
	begin : gPort
		mduIssuePort #(
			.CmdDepth(CmdDepth)
		) port (
			.clk(clk),
			.reset(reset),
			.cmdValid(cmdValid[i]),
			.cmdOp(cmdOp[i]),
			.cmdSrcA(cmdSrcA[i]),
			.cmdSrcB(cmdSrcB[i]),
			.grant(grant[i]),
			.respValid(respValid[i]),
			.respHi(respHi),
			.respLo(respLo),
			.cmdCredit(cmdCredit[i]),
			.reqValid(reqValid[i]),
			.reqOp(reqOp[i]),
			.reqSrcA(reqSrcA[i]),
			.reqSrcB(reqSrcB[i]),
			.hi(hi[i]),
			.lo(lo[i]),
			.done(done[i])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Shared engine and its arbiter
	//////////////////////////////////////////////////////////////////////

	mduArbiter #(
		.NumPorts(NumPorts)
	) arbiter (
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.reqOp(reqOp),
		.reqSrcA(reqSrcA),
		.reqSrcB(reqSrcB),
		.resultValid(resultValid),
		.resultHi(resultHi),
		.resultLo(resultLo),
		.grant(grant),
		.start(start),
		.op(engOp),
		.srcA(engSrcA),
		.srcB(engSrcB),
		.respValid(respValid),
		.respHi(respHi),
		.respLo(respLo)
	);

	mduEngine engine (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(engOp),
		.srcA(engSrcA),
		.srcB(engSrcB),
		.resultValid(resultValid),
		.resultHi(resultHi),
		.resultLo(resultLo)
	);

endmodule

/* verification/mduChecker.sv */
`timescale 1ns/1ps

module mduChecker #(
	parameter int NumPorts = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic [NumPorts-1:0] done,
	input  logic [NumPorts-1:0][mduPkg::DataWidth-1:0] hi,
	input  logic [NumPorts-1:0][mduPkg::DataWidth-1:0] lo,
	input  logic fairPhase,
	output int valueErrors,
	output int orderErrors,
	output int fairErrors
);
	import mduPkg::*;

	typedef struct packed {
		mduOp op;
		logic [DataWidth-1:0] a;
		logic [DataWidth-1:0] b;
	} cmdEntry;

	// Commands sent and not yet completed in oldest-first order
	cmdEntry pendQ [NumPorts][$];
	logic [DataWidth-1:0] modelHi [NumPorts];
	logic [DataWidth-1:0] modelLo [NumPorts];
	int lastEnginePort;
	int valueCount = 0;
	int orderCount = 0;
	int fairCount = 0;

	assign valueErrors = valueCount;
	assign orderErrors = orderCount;
	assign fairErrors = fairCount;

	//////////////////////////////////////////////////////////////////////
	// Reference model of one command with the result packed as {hi, lo}
	//////////////////////////////////////////////////////////////////////

	function automatic logic [2*DataWidth-1:0] refResult(
		input mduOp op,
		input logic [DataWidth-1:0] a,
		input logic [DataWidth-1:0] b,
		input logic [DataWidth-1:0] curHi,
		input logic [DataWidth-1:0] curLo
	);
		longint prod;
		logic negA;
		logic negB;
		logic [DataWidth-1:0] magA;
		logic [DataWidth-1:0] magB;
		logic [DataWidth-1:0] quo;
		logic [DataWidth-1:0] rem;

		negA = a[DataWidth-1];
		negB = b[DataWidth-1];
		magA = negA ? -a : a;
		magB = negB ? -b : b;
		case (op)
			opMult:
			begin
				prod = longint'($signed(a)) * longint'($signed(b));
				return prod;
			end
			opMultu:
			begin
				// Zero-extended operands give the unsigned product bits
				prod = longint'(a) * longint'(b);
				return prod;
			end
			opDiv:
			begin
				if (b == '0)
					return {a, {DataWidth{1'b1}}};
				else if (a == {1'b1, {(DataWidth - 1){1'b0}}} && b == '1)
					return {{DataWidth{1'b0}}, a};
				// Divide magnitudes and then fix the signs
				quo = magA / magB;
				rem = magA % magB;
				if (negA != negB)
					quo = -quo;
				if (negA)
					rem = -rem;
				return {rem, quo};
			end
			opDivu:
			begin
				if (b == '0)
					return {a, {DataWidth{1'b1}}};
				return {a % b, a / b};
			end
			opMthi:
				return {a, curLo};
			opMtlo:
				return {curHi, a};
			default:
				return {curHi, curLo};
		endcase
	endfunction

	task automatic addCommand(input int port, input mduOp op,
		input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b);
		pendQ[port].push_back({op, a, b});
	endtask

	function automatic logic queueEmpty(input int port);
		return pendQ[port].size() == 0;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Comparison on the falling edge
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin : compare
		cmdEntry entry;
		logic [2*DataWidth-1:0] expected;

		if (reset)
		begin
			for (int p = 0; p < NumPorts; p++)
			begin
				modelHi[p] = '0;
				modelLo[p] = '0;
			end
			lastEnginePort = -1;
		end
		else
		begin
			for (int p = 0; p < NumPorts; p++)
			begin
				if (done[p] && pendQ[p].size() == 0)
				begin
					$display("Port %0d signalled done with no command outstanding", p);
					orderCount++;
				end
				else if (done[p])
				begin
					entry = pendQ[p].pop_front();
					expected = refResult(entry.op, entry.a, entry.b, modelHi[p], modelLo[p]);
					modelHi[p] = expected[2*DataWidth-1:DataWidth];
					modelLo[p] = expected[DataWidth-1:0];
					if (entry.op != opMthi && entry.op != opMtlo)
					begin
						if (fairPhase && lastEnginePort == p)
						begin
							$display("Port %0d completed two engine operations in a row", p);
							fairCount++;
						end
						lastEnginePort = fairPhase ? p : -1;
					end
				end
				// Checked every cycle so a write from the other port shows up too
				if (hi[p] !== modelHi[p])
				begin
					$display("Error: hi[%0d] = %h, expected %h", p, hi[p], modelHi[p]);
					valueCount++;
					modelHi[p] = hi[p];
				end
				if (lo[p] !== modelLo[p])
				begin
					$display("Error: lo[%0d] = %h, expected %h", p, lo[p], modelLo[p]);
					valueCount++;
					modelLo[p] = lo[p];
				end
			end
		end
	end

endmodule

/* verification/mduClusterTb.sv */
`timescale 1ns/1ps

module mduClusterTb;
	import mduPkg::*;

	localparam int NumPorts = 2;
	localparam int CmdDepth = 4;
	localparam int ClkPeriod = 8;
	localparam int DirectedCount = 16;
	localparam int RandomCount = 40;
	localparam int FairCount = 8;
	localparam int CmdsPerPort = DirectedCount + RandomCount + FairCount;
	// Every command taken as a divide behind all other ports with a margin of two
	localparam int WatchdogNs = CmdsPerPort * (DivLatency + 4) * NumPorts * ClkPeriod * 2;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [NumPorts-1:0] cmdValid;
	mduOp [NumPorts-1:0] cmdOp;
	logic [NumPorts-1:0][DataWidth-1:0] cmdSrcA;
	logic [NumPorts-1:0][DataWidth-1:0] cmdSrcB;
	logic [NumPorts-1:0] cmdCredit;
	logic [NumPorts-1:0][DataWidth-1:0] hi;
	logic [NumPorts-1:0][DataWidth-1:0] lo;
	logic [NumPorts-1:0] done;

	logic fairGo = 1'b0;
	logic fairPhase = 1'b0;
	logic [NumPorts-1:0] drained;
	logic [NumPorts-1:0] finished;
	int creditErrCount [NumPorts];
	int valueErrors;
	int orderErrors;
	int fairErrors;

	always #(ClkPeriod / 2) clk = ~clk;

	mduCluster #(
		.NumPorts(NumPorts),
		.CmdDepth(CmdDepth)
	) UUT (
		.clk(clk),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmdOp(cmdOp),
		.cmdSrcA(cmdSrcA),
		.cmdSrcB(cmdSrcB),
		.cmdCredit(cmdCredit),
		.hi(hi),
		.lo(lo),
		.done(done)
	);

	mduChecker #(
		.NumPorts(NumPorts)
	) refCheck (
		.clk(clk),
		.reset(reset),
		.done(done),
		.hi(hi),
		.lo(lo),
		.fairPhase(fairPhase),
		.valueErrors(valueErrors),
		.orderErrors(orderErrors),
		.fairErrors(fairErrors)
	);

	// Corner values show up often
	function automatic logic [DataWidth-1:0] pickOperand();
		case ($urandom_range(7, 0))
			0: return '0;
			1: return '1;
			2: return {1'b1, {(DataWidth - 1){1'b0}}};
			3: return DataWidth'($urandom_range(15, 0));
			default: return DataWidth'($urandom);
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Per-port sender with credit tracking
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NumPorts; i++)
	begin : gStim
		logic sendValid = 1'b0;
		mduOp sendOp = opMult;
		logic [DataWidth-1:0] sendA = '0;
		logic [DataWidth-1:0] sendB = '0;
		int credits = CmdDepth;
		int creditErrors = 0;
		logic isDrained = 1'b0;
		logic isFinished = 1'b0;

		assign cmdValid[i] = sendValid;
		assign cmdOp[i] = sendOp;
		assign cmdSrcA[i] = sendA;
		assign cmdSrcB[i] = sendB;
		assign drained[i] = isDrained;
		assign finished[i] = isFinished;
		assign creditErrCount[i] = creditErrors;

		// Advance one falling edge and count any returned credit
		task automatic tick();
			@(negedge clk);
			sendValid = 1'b0;
			if (cmdCredit[i])
			begin
				if (credits >= CmdDepth)
				begin
					$display("Port %0d returned a credit while the sender held %0d", i, credits);
					creditErrors++;
				end
				else
					credits++;
			end
		endtask

		task automatic sendCmd(input mduOp op, input logic [DataWidth-1:0] a,
			input logic [DataWidth-1:0] b);
			while (credits == 0)
				tick();
			sendValid = 1'b1;
			sendOp = op;
			sendA = a;
			sendB = b;
			credits--;
			refCheck.addCommand(i, op, a, b);
			tick();
		endtask

		task automatic sendDirected();
			sendCmd(opMult, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
			sendCmd(opMultu, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
			sendCmd(opMult, 32'h8000_0000, 32'h7FFF_FFFF);
			sendCmd(opMult, 32'hFFFF_FFF9, 32'd3);
			sendCmd(opMultu, 32'h1234_5678, 32'h9ABC_DEF0);
			sendCmd(opDiv, 32'hFFFF_FFF9, 32'd2);
			sendCmd(opDiv, 32'd7, 32'hFFFF_FFFE);
			sendCmd(opDivu, 32'hFFFF_FFFF, 32'd3);
			sendCmd(opDiv, 32'd5, 32'd0);
			sendCmd(opDivu, 32'h8000_0000, 32'd0);
			sendCmd(opDiv, 32'h8000_0000, 32'hFFFF_FFFF);
			// Port number in the move data keeps the ports apart
			sendCmd(opMthi, 32'hA5A5_A5A0 + i, 32'd0);
			sendCmd(opMtlo, 32'h5A5A_5A50 + i, 32'd0);
			sendCmd(opMult, 32'd3, 32'd5);
			sendCmd(opMtlo, 32'h0F0F_0F00 + i, 32'd0);
			sendCmd(opDivu, 32'd100, 32'd7);
		endtask

		// All credits must be home once every command has completed
		task automatic drainPort();
			while (!refCheck.queueEmpty(i))
				tick();
			tick();
			if (credits != CmdDepth)
			begin
				$display("Port %0d holds %0d credits after draining, not %0d", i, credits, CmdDepth);
				creditErrors++;
			end
		endtask

		initial
		begin
			void'($urandom(45195));
			while (reset)
				tick();
			sendDirected();
			for (int n = 0; n < RandomCount; n++)
				sendCmd(mduOp'(3'($urandom_range(5, 0))), pickOperand(), pickOperand());
			drainPort();
			isDrained = 1'b1;
			while (!fairGo)
				tick();
			// Back-to-back multiplies only
			for (int n = 0; n < FairCount; n++)
				sendCmd((n % 2 == 0) ? opMult : opMultu, pickOperand(), pickOperand());
			drainPort();
			isFinished = 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Run control and watchdog
	//////////////////////////////////////////////////////////////////////

	initial
	begin : mainFlow
		int creditTotal;

		reset = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		wait (drained == '1);
		// Both senders see the go on the same falling edge
		@(posedge clk);
		fairGo = 1'b1;
		fairPhase = 1'b1;
		wait (finished == '1);
		@(negedge clk);
		fairPhase = 1'b0;
		creditTotal = 0;
		for (int p = 0; p < NumPorts; p++)
			creditTotal += creditErrCount[p];
		$display("Errors: %0d value, %0d order, %0d fairness, %0d credit",
			valueErrors, orderErrors, fairErrors, creditTotal);
		if (valueErrors + orderErrors + fairErrors + creditTotal == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial
	begin : watchdog
		#(WatchdogNs);
		$display("Timeout: the run did not complete within %0d ns", WatchdogNs);
		$display("sim failed");
		$finish;
	end

endmodule

/* src.f */
verilog/mduPkg.sv
verilog/mduIssuePort.sv
verilog/mduArbiter.sv
verilog/mduEngine.sv
verilog/mduCluster.sv
verification/mduChecker.sv
verification/mduClusterTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the MDU cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simBin=mduClusterSim
logFile=sim.log

# Compile
verilator --binary --timing --assert -Wno-fatal \
	--top-module mduClusterTb -f src.f \
	--Mdir "$buildDir" -o "$simBin"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Run, keeping the output for the search below
"./$buildDir/$simBin" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

# Verdict
if grep -q "sim failed" "$logFile"; then
	exit 1
fi
exit 0
